//--- logic/decode_control.sv
`timescale 1ns/1ps
`default_nettype none

module decode_control
    import mips_pkg::*;
(
    input  word_t    instr,
    output ctrl_t    ctrl,
    output npc_sel_e npc_sel,
    output logic     cmp_ne,
    output tcount_t  tuse_rs,
    output tcount_t  tuse_rt,
    output word_t    ext
);

    opcode_e   opcode;
    funct_e    funct;
    reg_addr_t rt;
    reg_addr_t rd;
    logic      r_alu;
    alu_op_e   r_op;
    logic      zero_ext;
    logic      we_raw;
    reg_addr_t dest;

    assign opcode = opcode_e'(instr[31:26]);
    assign funct  = funct_e'(instr[5:0]);
    assign rt     = instr[20:16];
    assign rd     = instr[15:11];

    // R-type ALU operation
    always_comb begin
        r_alu = 1'b1;
        r_op  = ALU_ADD;
        case (funct)
            FN_ADDU: r_op = ALU_ADD;
            FN_SUBU: r_op = ALU_SUB;
            FN_AND:  r_op = ALU_AND;
            FN_OR:   r_op = ALU_OR;
            FN_SLT:  r_op = ALU_SLT;
            default: r_alu = 1'b0;
        endcase
    end

    always_comb begin
        ctrl     = '0;
        npc_sel  = NPC_SEQ;
        cmp_ne   = 1'b0;
        tuse_rs  = TUSE_NONE;
        tuse_rt  = TUSE_NONE;
        zero_ext = 1'b0;
        we_raw   = 1'b0;
        dest     = '0;
        case (opcode)
            OP_SPECIAL: begin
                if (funct == FN_JR) begin
                    npc_sel = NPC_JREG;
                    tuse_rs = TUSE_D;
                end else if (r_alu) begin
                    ctrl.alu_op = r_op;
                    we_raw      = 1'b1;
                    dest        = rd;
                    tuse_rs     = TUSE_E;
                    tuse_rt     = TUSE_E;
                end
            end
            OP_ORI, OP_LUI: begin
                ctrl.alu_op      = (opcode == OP_ORI) ? ALU_OR : ALU_LUI;
                ctrl.alu_src_imm = 1'b1;
                zero_ext         = 1'b1;
                we_raw           = 1'b1;
                dest             = rt;
                tuse_rs          = (opcode == OP_ORI) ? TUSE_E : TUSE_NONE;
            end
            OP_LW: begin
                ctrl.alu_src_imm = 1'b1;
                ctrl.wr_src      = WR_MEM;
                we_raw           = 1'b1;
                dest             = rt;
                tuse_rs          = TUSE_E;
            end
            OP_SW: begin
                ctrl.alu_src_imm = 1'b1;
                ctrl.mem_we      = 1'b1;
                tuse_rs          = TUSE_E;
                tuse_rt          = TUSE_M;
            end
            OP_BEQ, OP_BNE: begin
                npc_sel = NPC_BRANCH;
                cmp_ne  = (opcode == OP_BNE);
                tuse_rs = TUSE_D;
                tuse_rt = TUSE_D;
            end
            OP_J: npc_sel = NPC_JUMP;
            OP_JAL: begin
                npc_sel     = NPC_JUMP;
                ctrl.wr_src = WR_PC8;
                we_raw      = 1'b1;
                dest        = 5'd31;
            end
            default: ;
        endcase
        // Writes to r0 are dropped here so no later stage sees them
        ctrl.dest   = dest;
        ctrl.reg_we = we_raw && (dest != 5'd0);
    end

    assign ext = zero_ext ? {16'h0000, instr[15:0]} : {{16{instr[15]}}, instr[15:0]};

endmodule

`default_nettype wire

//--- logic/exec_alu.sv
`timescale 1ns/1ps
`default_nettype none

module exec_alu
    import mips_pkg::*;
(
    input  word_t a,
    input  word_t b_reg,
    input  word_t imm,
    input  ctrl_t ctrl,
    output word_t ao
);

    word_t b;

    assign b = ctrl.alu_src_imm ? imm : b_reg;

    always_comb begin
        case (ctrl.alu_op)
            ALU_ADD: ao = a + b;
            ALU_SUB: ao = a - b;
            ALU_AND: ao = a & b;
            ALU_OR:  ao = a | b;
            // Signed compare
            ALU_SLT: ao = {31'd0, $signed(a) < $signed(b)};
            ALU_LUI: ao = {b[15:0], 16'h0000};
            default: ao = a + b;
        endcase
    end

endmodule

`default_nettype wire

//--- logic/fetch_unit.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_unit
    import mips_pkg::*;
#(
    parameter word_t RESET_PC = 32'h0000_3000
) (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        pc_en,
    input  npc_sel_e    npc_sel,
    input  logic        cmp_true,
    input  word_t       d_pc,
    input  logic [15:0] imm16,
    input  logic [25:0] imm26,
    input  word_t       jr_target,
    output word_t       pc
);

    word_t pc_plus4;
    word_t d_pc_plus4;
    word_t branch_target;
    word_t next_pc;

    assign pc_plus4      = pc + 32'd4;
    assign d_pc_plus4    = d_pc + 32'd4;
    // Offset counts words from the delay slot
    assign branch_target = d_pc_plus4 + {{14{imm16[15]}}, imm16, 2'b00};

    always_comb begin
        case (npc_sel)
            NPC_BRANCH: next_pc = cmp_true ? branch_target : pc_plus4;
            NPC_JUMP:   next_pc = {d_pc_plus4[31:28], imm26, 2'b00};
            NPC_JREG:   next_pc = jr_target;
            default:    next_pc = pc_plus4;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc <= RESET_PC;
        end else if (pc_en) begin
            pc <= next_pc;
        end
    end

endmodule

`default_nettype wire

//--- logic/hazard_unit.sv
`timescale 1ns/1ps
`default_nettype none

module hazard_unit
    import mips_pkg::*;
(
    input  reg_addr_t d_rs,
    input  reg_addr_t d_rt,
    input  tcount_t   tuse_rs,
    input  tcount_t   tuse_rt,
    input  de_t       de,
    input  em_t       em,
    input  reg_addr_t w_dest,
    input  logic      w_we,
    output logic      stall,
    output fwd_sel_e  fwd_d_rs,
    output fwd_sel_e  fwd_d_rt,
    output fwd_sel_e  fwd_e_a,
    output fwd_sel_e  fwd_e_b,
    output fwd_sel_e  fwd_m_wd
);

    function automatic logic hit(reg_addr_t src, reg_addr_t dest, logic we);
        return we && (dest != 5'd0) && (dest == src);
    endfunction

    // Nearest writer wins; a writer still computing blocks older ones
    function automatic fwd_sel_e pick(logic e_hit, logic m_hit, logic w_hit,
                                      tcount_t e_tnew, tcount_t m_tnew);
        if (e_hit) begin
            return (e_tnew == 2'd0) ? FWD_FROM_E : FWD_NONE;
        end
        if (m_hit) begin
            return (m_tnew == 2'd0) ? FWD_FROM_M : FWD_NONE;
        end
        return w_hit ? FWD_FROM_W : FWD_NONE;
    endfunction

    tcount_t m_tnew;
    logic    e_hit_rs;
    logic    e_hit_rt;
    logic    m_hit_rs;
    logic    m_hit_rt;

    // One cycle closer to ready once in M
    assign m_tnew = (em.tnew == 2'd0) ? 2'd0 : em.tnew - 2'd1;

    assign e_hit_rs = hit(d_rs, de.ctrl.dest, de.ctrl.reg_we);
    assign e_hit_rt = hit(d_rt, de.ctrl.dest, de.ctrl.reg_we);
    assign m_hit_rs = hit(d_rs, em.ctrl.dest, em.ctrl.reg_we);
    assign m_hit_rt = hit(d_rt, em.ctrl.dest, em.ctrl.reg_we);

    assign stall = (e_hit_rs && (de.tnew > tuse_rs)) || (m_hit_rs && (m_tnew > tuse_rs)) ||
                   (e_hit_rt && (de.tnew > tuse_rt)) || (m_hit_rt && (m_tnew > tuse_rt));

    assign fwd_d_rs = pick(e_hit_rs, m_hit_rs, hit(d_rs, w_dest, w_we), de.tnew, m_tnew);
    assign fwd_d_rt = pick(e_hit_rt, m_hit_rt, hit(d_rt, w_dest, w_we), de.tnew, m_tnew);

    // E operands only see M and W
    assign fwd_e_a = pick(1'b0, hit(de.rs, em.ctrl.dest, em.ctrl.reg_we),
                          hit(de.rs, w_dest, w_we), 2'd0, m_tnew);
    assign fwd_e_b = pick(1'b0, hit(de.rt, em.ctrl.dest, em.ctrl.reg_we),
                          hit(de.rt, w_dest, w_we), 2'd0, m_tnew);

    assign fwd_m_wd = hit(em.rt, w_dest, w_we) ? FWD_FROM_W : FWD_NONE;

endmodule

`default_nettype wire

//--- logic/mips_core.sv
`timescale 1ns/1ps
`default_nettype none

module mips_core
    import mips_pkg::*;
#(
    parameter word_t RESET_PC = 32'h0000_3000
) (
    input  logic      clk,
    input  logic      rst_n,
    output word_t     i_inst_addr,
    input  word_t     i_inst_rdata,
    output word_t     m_data_addr,
    input  word_t     m_data_rdata,
    output word_t     m_data_wdata,
    output logic      m_data_we,
    output logic      w_grf_we,
    output reg_addr_t w_grf_addr,
    output word_t     w_grf_wdata,
    output word_t     w_inst_addr
);

    function automatic word_t fwd_mux(fwd_sel_e sel, word_t raw, word_t e_val,
                                      word_t m_val, word_t w_val);
        case (sel)
            FWD_FROM_E: return e_val;
            FWD_FROM_M: return m_val;
            FWD_FROM_W: return w_val;
            default:    return raw;
        endcase
    endfunction

    fd_t       fd_q;
    de_t       de_q;
    de_t       de_d;
    em_t       em_q;
    em_t       em_d;
    mw_t       mw_q;
    mw_t       mw_d;
    word_t     f_pc;
    ctrl_t     d_ctrl;
    npc_sel_e  d_npc_sel;
    logic      d_cmp_ne;
    logic      d_cmp_true;
    tcount_t   d_tuse_rs;
    tcount_t   d_tuse_rt;
    tcount_t   d_tnew;
    word_t     d_ext;
    word_t     d_rd1;
    word_t     d_rd2;
    word_t     d_v1;
    word_t     d_v2;
    reg_addr_t d_rs;
    reg_addr_t d_rt;
    word_t     e_a;
    word_t     e_b;
    word_t     e_ao;
    word_t     e_wd;
    word_t     m_wd;
    word_t     w_wd;
    logic      stall;
    fwd_sel_e  fwd_d_rs;
    fwd_sel_e  fwd_d_rt;
    fwd_sel_e  fwd_e_a;
    fwd_sel_e  fwd_e_b;
    fwd_sel_e  fwd_m_wd;

    // --------------------------------------------------
    // F stage
    // --------------------------------------------------
    fetch_unit #(.RESET_PC(RESET_PC)) u_fetch (
        .clk       (clk),
        .rst_n     (rst_n),
        .pc_en     (!stall),
        .npc_sel   (d_npc_sel),
        .cmp_true  (d_cmp_true),
        .d_pc      (fd_q.pc),
        .imm16     (fd_q.instr[15:0]),
        .imm26     (fd_q.instr[25:0]),
        .jr_target (d_v1),
        .pc        (f_pc)
    );

    assign i_inst_addr = f_pc;

    // --------------------------------------------------
    // D stage
    // --------------------------------------------------
    assign d_rs = fd_q.instr[25:21];
    assign d_rt = fd_q.instr[20:16];

    decode_control u_decode (
        .instr   (fd_q.instr),
        .ctrl    (d_ctrl),
        .npc_sel (d_npc_sel),
        .cmp_ne  (d_cmp_ne),
        .tuse_rs (d_tuse_rs),
        .tuse_rt (d_tuse_rt),
        .ext     (d_ext)
    );

    reg_file u_reg_file (
        .clk   (clk),
        .rst_n (rst_n),
        .ra1   (d_rs),
        .ra2   (d_rt),
        .wa    (mw_q.ctrl.dest),
        .we    (mw_q.ctrl.reg_we),
        .wd    (w_wd),
        .rd1   (d_rd1),
        .rd2   (d_rd2)
    );

    assign d_v1       = fwd_mux(fwd_d_rs, d_rd1, e_wd, m_wd, w_wd);
    assign d_v2       = fwd_mux(fwd_d_rt, d_rd2, e_wd, m_wd, w_wd);
    assign d_cmp_true = (d_v1 == d_v2) ^ d_cmp_ne;

    always_comb begin
        case (d_ctrl.wr_src)
            WR_MEM:  d_tnew = TNEW_MEM;
            WR_PC8:  d_tnew = TNEW_PC8;
            default: d_tnew = TNEW_ALU;
        endcase
    end

    assign de_d = '{pc: fd_q.pc, v1: d_v1, v2: d_v2, ext: d_ext, rs: d_rs, rt: d_rt,
                    ctrl: d_ctrl, tnew: d_tnew};

    hazard_unit u_hazard (
        .d_rs     (d_rs),
        .d_rt     (d_rt),
        .tuse_rs  (d_tuse_rs),
        .tuse_rt  (d_tuse_rt),
        .de       (de_q),
        .em       (em_q),
        .w_dest   (mw_q.ctrl.dest),
        .w_we     (mw_q.ctrl.reg_we),
        .stall    (stall),
        .fwd_d_rs (fwd_d_rs),
        .fwd_d_rt (fwd_d_rt),
        .fwd_e_a  (fwd_e_a),
        .fwd_e_b  (fwd_e_b),
        .fwd_m_wd (fwd_m_wd)
    );

    // --------------------------------------------------
    // E stage
    // --------------------------------------------------
    assign e_a = fwd_mux(fwd_e_a, de_q.v1, e_wd, m_wd, w_wd);
    assign e_b = fwd_mux(fwd_e_b, de_q.v2, e_wd, m_wd, w_wd);

    exec_alu u_alu (
        .a     (e_a),
        .b_reg (e_b),
        .imm   (de_q.ext),
        .ctrl  (de_q.ctrl),
        .ao    (e_ao)
    );

    // Only the link value is final this early
    always_comb begin
        case (de_q.ctrl.wr_src)
            WR_PC8:  e_wd = de_q.pc + 32'd8;
            default: e_wd = e_ao;
        endcase
    end

    assign em_d = '{pc: de_q.pc, ao: e_ao, v2: e_b, rt: de_q.rt, ctrl: de_q.ctrl,
                    tnew: de_q.tnew};

    // --------------------------------------------------
    // M stage
    // --------------------------------------------------
    assign m_data_addr  = em_q.ao;
    assign m_data_wdata = fwd_mux(fwd_m_wd, em_q.v2, e_wd, m_wd, w_wd);
    assign m_data_we    = em_q.ctrl.mem_we;

    always_comb begin
        case (em_q.ctrl.wr_src)
            WR_PC8:  m_wd = em_q.pc + 32'd8;
            default: m_wd = em_q.ao;
        endcase
    end

    assign mw_d = '{pc: em_q.pc, ao: em_q.ao, rd_data: m_data_rdata, ctrl: em_q.ctrl};

    // --------------------------------------------------
    // W stage
    // --------------------------------------------------
    always_comb begin
        case (mw_q.ctrl.wr_src)
            WR_MEM:  w_wd = mw_q.rd_data;
            WR_PC8:  w_wd = mw_q.pc + 32'd8;
            default: w_wd = mw_q.ao;
        endcase
    end

    assign w_grf_we    = mw_q.ctrl.reg_we;
    assign w_grf_addr  = mw_q.ctrl.dest;
    assign w_grf_wdata = w_wd;
    assign w_inst_addr = mw_q.pc;

    // A stall freezes F/D and bubbles D/E
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            fd_q <= '{pc: RESET_PC, instr: NOP_INSTR};
            de_q <= '0;
            em_q <= '0;
            mw_q <= '0;
        end else begin
            if (!stall) begin
                fd_q <= '{pc: f_pc, instr: i_inst_rdata};
            end
            if (stall) begin
                de_q <= '0;
            end else begin
                de_q <= de_d;
            end
            em_q <= em_d;
            mw_q <= mw_d;
        end
    end

endmodule

`default_nettype wire

//--- logic/mips_pkg.sv
`default_nettype none

package mips_pkg;

    // --------------------------------------------------
    // Basic types
    // --------------------------------------------------
    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_addr_t;
    typedef logic [1:0]  tcount_t;

    typedef enum logic [5:0] {
        OP_SPECIAL = 6'h00,
        OP_J       = 6'h02,
        OP_JAL     = 6'h03,
        OP_BEQ     = 6'h04,
        OP_BNE     = 6'h05,
        OP_ORI     = 6'h0d,
        OP_LUI     = 6'h0f,
        OP_LW      = 6'h23,
        OP_SW      = 6'h2b
    } opcode_e;

    // R-type function field
    typedef enum logic [5:0] {
        FN_JR   = 6'h08,
        FN_ADDU = 6'h21,
        FN_SUBU = 6'h23,
        FN_AND  = 6'h24,
        FN_OR   = 6'h25,
        FN_SLT  = 6'h2a
    } funct_e;

    typedef enum logic [2:0] {ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_SLT, ALU_LUI} alu_op_e;
    typedef enum logic [1:0] {NPC_SEQ, NPC_BRANCH, NPC_JUMP, NPC_JREG} npc_sel_e;
    typedef enum logic [1:0] {FWD_NONE, FWD_FROM_E, FWD_FROM_M, FWD_FROM_W} fwd_sel_e;
    typedef enum logic [1:0] {WR_ALU, WR_MEM, WR_PC8} wr_src_e;

    // --------------------------------------------------
    // Control and pipeline registers
    // --------------------------------------------------
    typedef struct packed {
        alu_op_e   alu_op;
        logic      alu_src_imm;
        wr_src_e   wr_src;
        logic      reg_we;
        logic      mem_we;
        reg_addr_t dest;
    } ctrl_t;

    typedef struct packed {
        word_t pc;
        word_t instr;
    } fd_t;

    typedef struct packed {
        word_t     pc;
        word_t     v1;
        word_t     v2;
        word_t     ext;
        reg_addr_t rs;
        reg_addr_t rt;
        ctrl_t     ctrl;
        tcount_t   tnew;
    } de_t;

    // tnew here is still the E-stage count
    typedef struct packed {
        word_t     pc;
        word_t     ao;
        word_t     v2;
        reg_addr_t rt;
        ctrl_t     ctrl;
        tcount_t   tnew;
    } em_t;

    typedef struct packed {
        word_t pc;
        word_t ao;
        word_t rd_data;
        ctrl_t ctrl;
    } mw_t;

    // --------------------------------------------------
    // Hazard timing
    // --------------------------------------------------
    localparam tcount_t TUSE_D    = 2'd0;
    localparam tcount_t TUSE_E    = 2'd1;
    localparam tcount_t TUSE_M    = 2'd2;
    localparam tcount_t TUSE_NONE = 2'd3;

    localparam tcount_t TNEW_PC8 = 2'd0;
    localparam tcount_t TNEW_ALU = 2'd1;
    localparam tcount_t TNEW_MEM = 2'd2;

    localparam word_t NOP_INSTR = 32'h0000_0000;

endpackage

`default_nettype wire

//--- logic/reg_file.sv
`timescale 1ns/1ps
`default_nettype none

module reg_file
    import mips_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  reg_addr_t ra1,
    input  reg_addr_t ra2,
    input  reg_addr_t wa,
    input  logic      we,
    input  word_t     wd,
    output word_t     rd1,
    output word_t     rd2
);

    // r0 has no storage
    word_t regs [1:31];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we && (wa != 5'd0)) begin
            regs[wa] <= wd;
        end
    end

    assign rd1 = (ra1 == 5'd0) ? '0 : regs[ra1];
    assign rd2 = (ra2 == 5'd0) ? '0 : regs[ra2];

endmodule

`default_nettype wire

//--- mips_core.f
logic/mips_pkg.sv
logic/fetch_unit.sv
logic/decode_control.sv
logic/reg_file.sv
logic/hazard_unit.sv
logic/exec_alu.sv
logic/mips_core.sv
test/mips_core_properties.sv
test/mips_core_tb.sv

//--- test/mips_core_properties.sv
`timescale 1ns/1ps
`default_nettype none

module mips_core_properties
    import mips_pkg::*;
(
    input logic      clk,
    input logic      rst_n,
    input word_t     i_inst_addr,
    input logic      m_data_we,
    input logic      w_grf_we,
    input reg_addr_t w_grf_addr,
    input logic      stall
);

    int fail_count = 0;

    // r0 writes are dropped in decode
    a_no_r0_write: assert property (@(posedge clk) disable iff (!rst_n)
        w_grf_we |-> (w_grf_addr != 5'd0))
    else begin
        fail_count++;
        $error("register write reported for r0");
    end

    // Pipeline is full of bubbles for the first cycles out of reset
    a_no_store_after_reset: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(rst_n) |-> !m_data_we [*3])
    else begin
        fail_count++;
        $error("data write strobe active right after reset");
    end

    a_fetch_aligned: assert property (@(posedge clk) disable iff (!rst_n)
        i_inst_addr[1:0] == 2'b00)
    else begin
        fail_count++;
        $error("fetch address not word aligned");
    end

    a_stall_holds_pc: assert property (@(posedge clk) disable iff (!rst_n)
        stall |=> $stable(i_inst_addr))
    else begin
        fail_count++;
        $error("fetch address moved during a stall");
    end

endmodule

`default_nettype wire

//--- test/mips_core_tb.sv
`timescale 1ns/1ps
`default_nettype none

module mips_core_tb
    import mips_pkg::*;
();

    localparam word_t RESET_PC       = 32'h0000_3000;
    localparam int    TIMEOUT_CYCLES = 50;
    localparam int    EV_NONE        = 0;
    localparam int    EV_WB          = 1;
    localparam int    EV_ST          = 2;

    // One program row with the event it should cause
    typedef struct packed {
        word_t     instr;
        int        kind;
        reg_addr_t dest;
        word_t     data;
        word_t     addr;
        int        seq;
    } row_t;

    typedef struct packed {
        word_t     pc;
        reg_addr_t dest;
        word_t     data;
    } wb_obs_t;

    typedef struct packed {
        word_t addr;
        word_t data;
    } st_obs_t;

    logic      clk;
    logic      rst_n;
    word_t     i_inst_addr;
    word_t     i_inst_rdata;
    word_t     m_data_addr;
    word_t     m_data_rdata;
    word_t     m_data_wdata;
    logic      m_data_we;
    logic      w_grf_we;
    reg_addr_t w_grf_addr;
    word_t     w_grf_wdata;
    word_t     w_inst_addr;

    word_t     imem [0:63];
    word_t     dmem [0:255];
    word_t     imem_off;
    row_t      rows [$];
    string     test_names [$];
    int        test_start [$];
    wb_obs_t   wb_q [$];
    st_obs_t   st_q [$];
    int        error_count;
    int        failed_tests;

    mips_core #(.RESET_PC(RESET_PC)) UUT (
        .clk          (clk),
        .rst_n        (rst_n),
        .i_inst_addr  (i_inst_addr),
        .i_inst_rdata (i_inst_rdata),
        .m_data_addr  (m_data_addr),
        .m_data_rdata (m_data_rdata),
        .m_data_wdata (m_data_wdata),
        .m_data_we    (m_data_we),
        .w_grf_we     (w_grf_we),
        .w_grf_addr   (w_grf_addr),
        .w_grf_wdata  (w_grf_wdata),
        .w_inst_addr  (w_inst_addr)
    );

    bind mips_core mips_core_properties u_props (
        .clk         (clk),
        .rst_n       (rst_n),
        .i_inst_addr (i_inst_addr),
        .m_data_we   (m_data_we),
        .w_grf_we    (w_grf_we),
        .w_grf_addr  (w_grf_addr),
        .stall       (stall)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // --------------------------------------------------
    // Memory models
    // --------------------------------------------------
    assign imem_off     = i_inst_addr - RESET_PC;
    assign i_inst_rdata = (imem_off < 32'd256) ? imem[imem_off[7:2]] : NOP_INSTR;
    assign m_data_rdata = dmem[m_data_addr[9:2]];

    always @(posedge clk) begin
        if (m_data_we) begin
            dmem[m_data_addr[9:2]] <= m_data_wdata;
        end
    end

    // Record W-stage writes and M-stage stores at mid-cycle
    always @(negedge clk) begin
        if (rst_n && w_grf_we) begin
            wb_q.push_back('{pc: w_inst_addr, dest: w_grf_addr, data: w_grf_wdata});
        end
        if (rst_n && m_data_we) begin
            st_q.push_back('{addr: m_data_addr, data: m_data_wdata});
        end
    end

    function automatic word_t fill_word(word_t addr);
        return addr ^ 32'hc0de_0000;
    endfunction

    // --------------------------------------------------
    // Instruction encoders
    // --------------------------------------------------
    function automatic word_t enc_r(funct_e fn, int rs, int rt, int rd);
        return {OP_SPECIAL, rs[4:0], rt[4:0], rd[4:0], 5'd0, fn};
    endfunction

    function automatic word_t enc_i(opcode_e op, int rs, int rt, logic [15:0] imm);
        return {op, rs[4:0], rt[4:0], imm};
    endfunction

    function automatic word_t enc_j(opcode_e op, word_t target);
        return {op, target[27:2]};
    endfunction

    task automatic begin_test(input string name);
        test_names.push_back(name);
        test_start.push_back(rows.size());
    endtask

    task automatic wb_row(input word_t instr, input int dest, input word_t value, input int seq);
        rows.push_back('{instr: instr, kind: EV_WB, dest: dest[4:0], data: value, addr: '0,
                         seq: seq});
    endtask

    task automatic st_row(input word_t instr, input word_t addr, input word_t value,
                          input int seq);
        rows.push_back('{instr: instr, kind: EV_ST, dest: '0, data: value, addr: addr,
                         seq: seq});
    endtask

    task automatic plain_row(input word_t instr);
        rows.push_back('{instr: instr, kind: EV_NONE, dest: '0, data: '0, addr: '0, seq: -1});
    endtask

    // --------------------------------------------------
    // Program table with seq as the event order
    // --------------------------------------------------
    task automatic build_table();
        begin_test("alu ops");
        wb_row(enc_i(OP_ORI, 0, 1, 16'h1234), 1, 32'h0000_1234, 0);
        wb_row(enc_i(OP_LUI, 0, 2, 16'habcd), 2, 32'habcd_0000, 1);
        wb_row(enc_i(OP_ORI, 0, 3, 16'h00ff), 3, 32'h0000_00ff, 2);
        wb_row(enc_r(FN_ADDU, 1, 3, 4), 4, 32'h0000_1333, 3);
        wb_row(enc_r(FN_SUBU, 3, 1, 5), 5, 32'hffff_eecb, 4);
        wb_row(enc_r(FN_AND, 1, 3, 6), 6, 32'h0000_0034, 5);
        wb_row(enc_r(FN_OR, 2, 1, 7), 7, 32'habcd_1234, 6);
        wb_row(enc_r(FN_SLT, 2, 1, 8), 8, 32'h0000_0001, 7);
        wb_row(enc_r(FN_SLT, 1, 3, 9), 9, 32'h0000_0000, 8);

        begin_test("forwarding chain");
        wb_row(enc_i(OP_ORI, 0, 1, 16'h0005), 1, 32'h0000_0005, 0);
        wb_row(enc_r(FN_ADDU, 1, 1, 2), 2, 32'h0000_000a, 1);
        wb_row(enc_r(FN_ADDU, 2, 1, 3), 3, 32'h0000_000f, 2);
        wb_row(enc_r(FN_SUBU, 3, 2, 4), 4, 32'h0000_0005, 3);
        wb_row(enc_r(FN_OR, 4, 3, 5), 5, 32'h0000_000f, 4);
        wb_row(enc_i(OP_ORI, 5, 5, 16'h0030), 5, 32'h0000_003f, 5);
        wb_row(enc_r(FN_ADDU, 5, 5, 6), 6, 32'h0000_007e, 6);

        begin_test("store and load");
        wb_row(enc_i(OP_ORI, 0, 1, 16'h0040), 1, 32'h0000_0040, 0);
        wb_row(enc_i(OP_ORI, 0, 2, 16'h5a5a), 2, 32'h0000_5a5a, 1);
        st_row(enc_i(OP_SW, 1, 2, 16'h0004), 32'h0000_0044, 32'h0000_5a5a, 2);
        wb_row(enc_i(OP_LW, 1, 3, 16'h0004), 3, 32'h0000_5a5a, 3);
        wb_row(enc_r(FN_ADDU, 3, 3, 4), 4, 32'h0000_b4b4, 4);
        st_row(enc_i(OP_SW, 1, 4, 16'h0000), 32'h0000_0040, 32'h0000_b4b4, 5);
        wb_row(enc_i(OP_LW, 1, 5, 16'h0000), 5, 32'h0000_b4b4, 6);
        wb_row(enc_i(OP_LW, 0, 6, 16'h0080), 6, 32'hc0de_0080, 7);

        begin_test("branches");
        wb_row(enc_i(OP_ORI, 0, 1, 16'h0007), 1, 32'h0000_0007, 0);
        wb_row(enc_i(OP_ORI, 0, 2, 16'h0007), 2, 32'h0000_0007, 1);
        plain_row(enc_i(OP_BEQ, 1, 2, 16'h0002));
        wb_row(enc_i(OP_ORI, 0, 3, 16'h0011), 3, 32'h0000_0011, 2);
        plain_row(enc_i(OP_ORI, 0, 4, 16'h0022));
        plain_row(enc_i(OP_BNE, 1, 2, 16'h0003));
        wb_row(enc_i(OP_ORI, 0, 5, 16'h0033), 5, 32'h0000_0033, 3);
        wb_row(enc_i(OP_ORI, 0, 6, 16'h0044), 6, 32'h0000_0044, 4);

        begin_test("jal and jr");
        wb_row(enc_j(OP_JAL, RESET_PC + 32'h14), 31, RESET_PC + 32'h8, 0);
        wb_row(enc_i(OP_ORI, 0, 1, 16'h0001), 1, 32'h0000_0001, 1);
        wb_row(enc_i(OP_ORI, 0, 2, 16'h0002), 2, 32'h0000_0002, 4);
        plain_row(enc_j(OP_J, RESET_PC + 32'h24));
        wb_row(enc_i(OP_ORI, 0, 3, 16'h0003), 3, 32'h0000_0003, 5);
        wb_row(enc_i(OP_ORI, 0, 5, 16'h0005), 5, 32'h0000_0005, 2);
        plain_row(enc_r(FN_JR, 31, 0, 0));
        wb_row(enc_i(OP_ORI, 0, 6, 16'h0006), 6, 32'h0000_0006, 3);
        plain_row(enc_i(OP_ORI, 0, 7, 16'h0007));

        begin_test("register zero");
        wb_row(enc_i(OP_ORI, 0, 1, 16'h0009), 1, 32'h0000_0009, 0);
        plain_row(enc_i(OP_ORI, 0, 0, 16'h0055));
        wb_row(enc_r(FN_ADDU, 0, 1, 2), 2, 32'h0000_0009, 1);
        plain_row(enc_r(FN_ADDU, 1, 1, 0));
        wb_row(enc_r(FN_OR, 0, 0, 3), 3, 32'h0000_0000, 2);
    endtask

    // --------------------------------------------------
    // Compare tasks
    // --------------------------------------------------
    task automatic check_word(input string name, input word_t got, input word_t exp);
        if (got !== exp) begin
            $display("MISMATCH time=%0t %s got=%h expected=%h", $time, name, got, exp);
            error_count++;
        end
    endtask

    task automatic check_reg(input string name, input reg_addr_t got, input reg_addr_t exp);
        if (got !== exp) begin
            $display("MISMATCH time=%0t %s got=%0d expected=%0d", $time, name, got, exp);
            error_count++;
        end
    endtask

    function automatic logic queue_empty(int kind);
        return (kind == EV_WB) ? (wb_q.size() == 0) : (st_q.size() == 0);
    endfunction

    task automatic wait_event(input int kind, output logic ok);
        int cycles;
        cycles = 0;
        while (queue_empty(kind) && cycles < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycles++;
        end
        ok = !queue_empty(kind);
    endtask

    function automatic int find_row(int first, int last, int seq);
        for (int i = first; i < last; i++) begin
            if (rows[i].kind != EV_NONE && rows[i].seq == seq) begin
                return i;
            end
        end
        return -1;
    endfunction

    task automatic init_memories(input int first, input int last);
        for (int i = 0; i < 64; i++) begin
            imem[i] = NOP_INSTR;
        end
        for (int i = first; i < last; i++) begin
            imem[i - first] = rows[i].instr;
        end
        for (int i = 0; i < 256; i++) begin
            dmem[i] = fill_word(32'(i) << 2);
        end
    endtask

    task automatic run_test(input int t);
        int      first;
        int      last;
        int      errors_before;
        int      idx;
        logic    ok;
        wb_obs_t wb;
        st_obs_t st;
        first         = test_start[t];
        last          = (t + 1 < test_start.size()) ? test_start[t + 1] : rows.size();
        errors_before = error_count;
        @(posedge clk);
        #1 rst_n = 1'b0;
        init_memories(first, last);
        wb_q.delete();
        st_q.delete();
        repeat (8) @(posedge clk);
        // Fetch starts at the reset vector
        check_word("i_inst_addr", i_inst_addr, RESET_PC);
        #1 rst_n = 1'b1;
        for (int s = 0; s < last - first; s++) begin
            idx = find_row(first, last, s);
            if (idx < 0) begin
                break;
            end
            wait_event(rows[idx].kind, ok);
            if (!ok) begin
                $display("Timeout in test %s: no %s from row %0d within %0d cycles",
                         test_names[t], (rows[idx].kind == EV_WB) ? "register write" : "store",
                         idx - first, TIMEOUT_CYCLES);
                error_count++;
                break;
            end
            if (rows[idx].kind == EV_WB) begin
                wb = wb_q.pop_front();
                check_word("w_inst_addr", wb.pc, RESET_PC + 32'(4 * (idx - first)));
                check_reg("w_grf_addr", wb.dest, rows[idx].dest);
                check_word("w_grf_wdata", wb.data, rows[idx].data);
            end else begin
                st = st_q.pop_front();
                check_word("m_data_addr", st.addr, rows[idx].addr);
                check_word("m_data_wdata", st.data, rows[idx].data);
            end
        end
        // Let skipped or stray instructions reach W
        repeat (10) @(posedge clk);
        while (wb_q.size() != 0) begin
            wb = wb_q.pop_front();
            $display("Unexpected register write to r%0d from instruction at %h",
                     wb.dest, wb.pc);
            error_count++;
        end
        while (st_q.size() != 0) begin
            st = st_q.pop_front();
            $display("Unexpected store to address %h", st.addr);
            error_count++;
        end
        if (error_count == errors_before) begin
            $display("Test %0d (%s): passed", t, test_names[t]);
        end else begin
            $display("Test %0d (%s): %0d errors", t, test_names[t], error_count - errors_before);
            failed_tests++;
        end
    endtask

    initial begin
        rst_n        = 1'b0;
        error_count  = 0;
        failed_tests = 0;
        init_memories(0, 0);
        build_table();
        for (int t = 0; t < test_start.size(); t++) begin
            run_test(t);
        end
        if (UUT.u_props.fail_count != 0) begin
            $display("Bound assertions failed %0d times", UUT.u_props.fail_count);
            error_count++;
        end
        $display("Tests run: %0d, tests failed: %0d, errors: %0d",
                 test_start.size(), failed_tests, error_count);
        if (error_count == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
